/* hdl/floatPkg.sv */
`default_nettype none

package floatPkg;

	// ############################################################
	// Single-precision field layout

	localparam int expWidth = 8;
	localparam int fracWidth = 23;
	localparam int expBias = 127;
	localparam int expMax = 255;

	typedef logic [expWidth+fracWidth:0] float32;
	typedef logic [expWidth-1:0] floatExp;
	// Hidden bit included
	typedef logic [fracWidth:0] floatMant;

	typedef struct packed {
		logic sign;
		floatExp exp;
		floatMant mant;
	} floatParts;

	// ############################################################
	// Operand unpacking, denormals flush to zero

	function automatic floatParts toParts(input float32 w);
		floatParts u;
		u.sign = w[expWidth+fracWidth];
		u.exp = w[expWidth+fracWidth-1:fracWidth];
		u.mant = {1'b1, w[fracWidth-1:0]};
		if (u.exp == '0)
			u.mant = '0;
		return u;
	endfunction

endpackage

`default_nettype wire

/* hdl/neuronPkg.sv */
`default_nettype none

package neuronPkg;

	// ############################################################
	// Neuron dimensions

	localparam int numInputs = 8;
	localparam int laneInputs = 4;

	// ############################################################
	// Fixed weights and bias

	localparam floatPkg::float32 weights [numInputs] = '{
		32'h3f00_0000,	// 0.5
		32'hbf80_0000,	// -1.0
		32'h4000_0000,	// 2.0
		32'h3e80_0000,	// 0.25
		32'hbf40_0000,	// -0.75
		32'h3fc0_0000,	// 1.5
		32'hc000_0000,	// -2.0
		32'h3f80_0000	// 1.0
	};

	localparam floatPkg::float32 bias = 32'h3f00_0000;

	// Element i sits at val[i]
	typedef struct packed {
		floatPkg::float32 [laneInputs-1:0] val;
	} laneVec;

	typedef struct packed {
		laneVec high;
		laneVec low;
	} neuronIn;

endpackage

`default_nettype wire

/* hdl/floatMult.sv */
`timescale 1ns/1ps
`default_nettype none

module floatMult
(
	input wire floatPkg::float32 a,
	input wire floatPkg::float32 b,
	output floatPkg::float32 p
);

	floatPkg::floatParts opA;
	floatPkg::floatParts opB;
	floatPkg::floatParts res;
	logic [47:0] mantProd;
	logic signed [9:0] expSum;

	always_comb
	begin
		opA = floatPkg::toParts(a);
		opB = floatPkg::toParts(b);
		mantProd = opA.mant * opB.mant;
		expSum = 10'(opA.exp) + 10'(opB.exp) - 10'(floatPkg::expBias);
		res.sign = opA.sign ^ opB.sign;

		// Product lies in [1,4), so one shift at most
		if (mantProd[47])
		begin
			res.mant = mantProd[47:24];
			expSum = expSum + 10'sd1;
		end
		else
		begin
			res.mant = mantProd[46:23];
		end
		res.exp = expSum[7:0];

		if (opA.mant == '0 || opB.mant == '0 || expSum <= 0)
		begin
			p = '0;
		end
		else if (expSum >= floatPkg::expMax)
		begin
			// Saturate to signed infinity
			p = {res.sign, 8'hff, 23'd0};
		end
		else
		begin
			p = {res.sign, res.exp, res.mant[22:0]};
		end
	end

endmodule

`default_nettype wire

/* hdl/floatAdd.sv */
`timescale 1ns/1ps
`default_nettype none

module floatAdd
(
	input wire floatPkg::float32 a,
	input wire floatPkg::float32 b,
	output floatPkg::float32 s
);

	floatPkg::floatParts opA;
	floatPkg::floatParts opB;
	floatPkg::floatParts big;
	floatPkg::floatParts smallOp;
	floatPkg::floatParts res;
	floatPkg::floatExp expDiff;
	logic [53:0] shifted;
	logic sticky;
	// Mantissa plus guard, round and sticky positions
	logic [26:0] alignMant;
	logic [27:0] mantSum;
	logic [26:0] normMant;
	logic [4:0] lz;
	logic signed [9:0] expNorm;

	function automatic logic [4:0] lzc(input logic [26:0] v);
		logic [4:0] n;
		n = 5'd27;
		for (int i = 0; i < 27; i++)
		begin
			if (v[i])
				n = 5'(26 - i);
		end
		return n;
	endfunction

	always_comb
	begin
		opA = floatPkg::toParts(a);
		opB = floatPkg::toParts(b);

		// Larger magnitude first
		if ({opA.exp, opA.mant} >= {opB.exp, opB.mant})
		begin
			big = opA;
			smallOp = opB;
		end
		else
		begin
			big = opB;
			smallOp = opA;
		end

		// ############################################################
		// Alignment of the smaller operand
		expDiff = big.exp - smallOp.exp;
		shifted = {smallOp.mant, 3'b000, 27'd0} >> expDiff;
		if (expDiff >= 8'd27)
			sticky = (smallOp.mant != '0);
		else
			sticky = (shifted[26:0] != '0);
		alignMant = shifted[53:27] | 27'(sticky);

		if (big.sign == smallOp.sign)
			mantSum = {1'b0, big.mant, 3'b000} + {1'b0, alignMant};
		else
			mantSum = {1'b0, big.mant, 3'b000} - {1'b0, alignMant};

		// ############################################################
		// Normalization with the low bits dropped
		lz = lzc(mantSum[26:0]);
		if (mantSum[27])
		begin
			normMant = mantSum[27:1];
			expNorm = 10'(big.exp) + 10'sd1;
		end
		else
		begin
			normMant = mantSum[26:0] << lz;
			expNorm = 10'(big.exp) - 10'(lz);
		end

		res.sign = big.sign;
		res.exp = expNorm[7:0];
		res.mant = normMant[26:3];

		// Exact cancellation ends up here as positive zero
		if (mantSum == '0 || expNorm <= 0)
		begin
			s = '0;
		end
		else if (expNorm >= floatPkg::expMax)
		begin
			s = {res.sign, 8'hff, 23'd0};
		end
		else
		begin
			s = {res.sign, res.exp, res.mant[22:0]};
		end
	end

endmodule

`default_nettype wire

/* hdl/dotLane.sv */
`timescale 1ns/1ps
`default_nettype none

module dotLane
#(
	parameter int laneIndex = 0
)
(
	input wire clk,
	input wire rst,
	input wire inVld,
	input wire neuronPkg::laneVec inVec,
	output floatPkg::float32 sum,
	output logic sumVld
);

	floatPkg::float32 prodComb [neuronPkg::laneInputs];
	floatPkg::float32 prodReg [neuronPkg::laneInputs];
	floatPkg::float32 pairComb [2];
	floatPkg::float32 pairReg [2];
	floatPkg::float32 sumComb;
	logic [2:0] vldPipe;

	// ############################################################
	// Products against this lane's slice of the weight table

	for (genvar i = 0; i < neuronPkg::laneInputs; i++)
	begin : gMult
		floatMult floatMult_i
		(
			.a(inVec.val[i]),
			.b(neuronPkg::weights[laneIndex*neuronPkg::laneInputs+i]),
			.p(prodComb[i])
		);
	end

	// ############################################################
	// Two-level adder tree

	for (genvar j = 0; j < 2; j++)
	begin : gPair
		floatAdd pairAdd_i
		(
			.a(prodReg[2*j]),
			.b(prodReg[2*j+1]),
			.s(pairComb[j])
		);
	end

	floatAdd finalAdd_i
	(
		.a(pairReg[0]),
		.b(pairReg[1]),
		.s(sumComb)
	);

	always_ff @(posedge clk)
	begin
		prodReg <= prodComb;
		pairReg <= pairComb;
		sum <= sumComb;
	end

	// Valid follows the three data stages
	always_ff @(posedge clk)
	begin
		if (rst)
			vldPipe <= '0;
		else
			vldPipe <= {vldPipe[1:0], inVld};
	end

	assign sumVld = vldPipe[2];

endmodule

`default_nettype wire

/* hdl/neuronActivate.sv */
`timescale 1ns/1ps
`default_nettype none

module neuronActivate
(
	input wire clk,
	input wire rst,
	input wire sumVld,
	input wire floatPkg::float32 sumLow,
	input wire floatPkg::float32 sumHigh,
	output logic outVld,
	output floatPkg::float32 outData
);

	floatPkg::float32 laneSum;
	floatPkg::float32 biasSum;

	// Lane sums, then bias, in one cycle
	floatAdd laneAdd_i
	(
		.a(sumLow),
		.b(sumHigh),
		.s(laneSum)
	);

	floatAdd biasAdd_i
	(
		.a(laneSum),
		.b(neuronPkg::bias),
		.s(biasSum)
	);

	// ############################################################
	// ReLU and output register

	always_ff @(posedge clk)
	begin
		if (biasSum[31])
			outData <= '0;
		else
			outData <= biasSum;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			outVld <= 1'b0;
		else
			outVld <= sumVld;
	end

endmodule

`default_nettype wire

/* hdl/neuronTop.sv */
`timescale 1ns/1ps
`default_nettype none

module neuronTop
(
	input wire clk,
	input wire rst,
	input wire inVld,
	input wire neuronPkg::neuronIn inData,
	output logic outVld,
	output floatPkg::float32 outData
);

	floatPkg::float32 lowSum;
	floatPkg::float32 highSum;
	logic lowSumVld;

	// Weights 0 to 3
	dotLane
	#(
		.laneIndex(0)
	)
	lowLane_i
	(
		.clk(clk),
		.rst(rst),
		.inVld(inVld),
		.inVec(inData.low),
		.sum(lowSum),
		.sumVld(lowSumVld)
	);

	// Weights 4 to 7, strobe matches the low lane
	dotLane
	#(
		.laneIndex(1)
	)
	highLane_i
	(
		.clk(clk),
		.rst(rst),
		.inVld(inVld),
		.inVec(inData.high),
		.sum(highSum),
		.sumVld()
	);

	neuronActivate neuronActivate_i
	(
		.clk(clk),
		.rst(rst),
		.sumVld(lowSumVld),
		.sumLow(lowSum),
		.sumHigh(highSum),
		.outVld(outVld),
		.outData(outData)
	);

endmodule

`default_nettype wire

/* dv/neuronTests.svh */
`ifndef NEURON_TESTS_SVH
`define NEURON_TESTS_SVH

// ############################################################
// Stimulus helpers

function automatic neuronPkg::neuronIn packInputs();
	neuronPkg::neuronIn v;
	for (int i = 0; i < neuronPkg::laneInputs; i++)
	begin
		v.low.val[i] = realToWord(stim[i]);
		v.high.val[i] = realToWord(stim[neuronPkg::laneInputs+i]);
	end
	return v;
endfunction

task automatic sendVector(input neuronPkg::neuronIn v);
	@(posedge clk);
	inVld <= 1'b1;
	inData <= v;
	expQ.push_back(neuronModel(v));
endtask

task automatic idleCycles(input int n);
	repeat (n)
	begin
		@(posedge clk);
		inVld <= 1'b0;
	end
endtask

task automatic drainResults();
	idleCycles(1);
	while (expQ.size() != 0)
		@(posedge clk);
endtask

// ############################################################
// Directed tests

task automatic idleOutput();
	repeat (20)
	begin
		@(negedge clk);
		assert (outVld === 1'b0)
		else
		begin
			$display("outVld went high at %0t with no input applied", $time);
			stopRun();
		end
	end
endtask

task automatic singleVector();
	stim = '{1.5, -2.0, 3.0, 4.0, 2.5, 6.0, -1.0, 8.0};
	sendVector(packInputs());
	drainResults();
endtask

// Sum plus bias is -16.5
task automatic negativeSum();
	stim = '{1.0, 8.5, 0.5, 2.0, 4.0, -1.0, 3.0, 0.0};
	sendVector(packInputs());
	drainResults();
endtask

task automatic zeroInputs();
	neuronPkg::neuronIn v;
	v.low.val[0] = 32'h0000_0000;
	v.low.val[1] = 32'h8000_0000;
	v.low.val[2] = 32'h0000_0001;
	v.low.val[3] = 32'h007f_ffff;
	v.high.val[0] = 32'h8040_0000;
	v.high.val[1] = 32'h0012_3456;
	v.high.val[2] = 32'h807f_ffff;
	v.high.val[3] = 32'h0000_0000;
	sendVector(v);
	drainResults();
endtask

task automatic backToBack();
	for (int i = 0; i < 8; i++)
	begin
		for (int j = 0; j < 8; j++)
			stim[j] = real'(i - j) + ((j % 2 == 1) ? 0.5 : 0.0);
		sendVector(packInputs());
	end
	drainResults();
endtask

task automatic randomVectors();
	for (int n = 0; n < 40; n++)
	begin
		for (int j = 0; j < 8; j++)
			stim[j] = real'(nextInt());
		sendVector(packInputs());
		// Occasional bubble
		if (nextInt() > 40)
			idleCycles(1);
	end
	drainResults();
endtask

`endif

/* dv/neuronTb.sv */
`timescale 1ns/1ps
`default_nettype none

module neuronTb;

	localparam int timeoutCycles = 400;

	logic clk;
	logic rst;
	logic inVld;
	neuronPkg::neuronIn inData;
	logic outVld;
	floatPkg::float32 outData;

	floatPkg::float32 expQ [$];
	floatPkg::float32 expWord;
	logic [3:0] vldHist;
	logic [31:0] rngState;
	real stim [8];
	int cycleCount;

	neuronTop neuronTop_i
	(
		.clk(clk),
		.rst(rst),
		.inVld(inVld),
		.inData(inData),
		.outVld(outVld),
		.outData(outData)
	);

	always #50 clk = ~clk;

	// ############################################################
	// Reference model in real arithmetic

	function automatic real wordToReal(input floatPkg::float32 w);
		real mag;
		int e;
		// Zero and denormals count as zero
		if (w[30:23] == 8'd0)
			return 0.0;
		mag = 1.0 + real'(w[22:0]) / 8388608.0;
		e = int'(w[30:23]) - floatPkg::expBias;
		for (; e > 0; e--)
			mag = mag * 2.0;
		for (; e < 0; e++)
			mag = mag / 2.0;
		return w[31] ? -mag : mag;
	endfunction

	function automatic floatPkg::float32 realToWord(input real v);
		real mag;
		int e;
		logic sign;
		if (v == 0.0)
			return '0;
		sign = (v < 0.0);
		mag = sign ? -v : v;
		e = 0;
		for (; mag >= 2.0; e++)
			mag = mag / 2.0;
		for (; mag < 1.0; e--)
			mag = mag * 2.0;
		return {sign, 8'(e + floatPkg::expBias), 23'($rtoi((mag - 1.0) * 8388608.0))};
	endfunction

	function automatic floatPkg::float32 neuronModel(input neuronPkg::neuronIn v);
		real acc;
		acc = wordToReal(neuronPkg::bias);
		for (int i = 0; i < neuronPkg::laneInputs; i++)
		begin
			acc = acc + wordToReal(v.low.val[i]) * wordToReal(neuronPkg::weights[i]);
			acc = acc + wordToReal(v.high.val[i])
				* wordToReal(neuronPkg::weights[neuronPkg::laneInputs+i]);
		end
		// ReLU
		if (acc <= 0.0)
			return '0;
		return realToWord(acc);
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Integer in -64..64
	function automatic int nextInt();
		rngState = xorshift(rngState);
		return int'(rngState % 32'd129) - 64;
	endfunction

	task automatic stopRun();
		$display("Verification failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	// ############################################################
	// Output checker
	// Strobe must trail inVld by four cycles

	always @(posedge clk)
	begin
		if (!rst)
		begin
			assert (outVld === vldHist[3])
			else
			begin
				$display("outVld does not follow inVld by four cycles at %0t", $time);
				stopRun();
			end
			if (outVld)
			begin
				assert (expQ.size() != 0)
				else
				begin
					$display("outVld came at %0t with no result expected", $time);
					stopRun();
				end
				expWord = expQ.pop_front();
				assert (outData === expWord)
				else
				begin
					$display("Error at %0t: outData %h, expected %h", $time, outData, expWord);
					stopRun();
				end
			end
		end
		vldHist <= {vldHist[2:0], inVld};
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Timeout: tests did not finish within %0d cycles", timeoutCycles);
			stopRun();
		end
	end

	`include "neuronTests.svh"

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		inVld = 1'b0;
		inData = '0;
		vldHist = '0;
		rngState = 32'h63eaad9d;
		cycleCount = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		idleOutput();
		singleVector();
		negativeSum();
		zeroInputs();
		backToBack();
		randomVectors();
		idleCycles(6);
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+dv
hdl/floatPkg.sv
hdl/neuronPkg.sv
hdl/floatMult.sv
hdl/floatAdd.sv
hdl/dotLane.sv
hdl/neuronActivate.sv
hdl/neuronTop.sv
dv/neuronTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal -j 0
TOP      = neuronTb
FILELIST = vlog.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(wildcard hdl/*.sv dv/*.sv dv/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(OBJDIR)
